// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  output word_t  pc_to_imem,
  input  insn_t  insn_from_imem,
  output logic   halt,
  output trace_t trace
);

  fd_t      fd;
  dx_t      dx;
  xm_t      xm;
  logic     redirect;
  word_t    redirect_pc;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  bypass_t  w_byp;

  rv_fetch u_fetch (
    .clk            (clk),
    .rst            (rst),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .fd             (fd)
  );

  rv_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .redirect (redirect),
    .fd       (fd),
    .dx       (dx)
  );

  // read in execute, written from writeback
  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (w_byp)
  );

  rv_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .dx          (dx),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .w_byp       (w_byp),
    .rs1         (rs1),
    .rs2         (rs2),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .xm          (xm)
  );

  rv_retire u_retire (
    .clk   (clk),
    .rst   (rst),
    .xm    (xm),
    .w_byp (w_byp),
    .halt  (halt),
    .trace (trace)
  );

endmodule

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decode import rv_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic redirect,
  input  fd_t  fd,
  output dx_t  dx
);

  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_REG_IMM = 7'b0010011;
  localparam logic [6:0] OPC_REG_REG = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;

  logic [6:0] funct7;
  reg_idx_t   rs2;
  reg_idx_t   rs1;
  logic [2:0] funct3;
  reg_idx_t   rd;
  logic [6:0] opcode;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm;
  op_t        op;

  // R-type split, other formats reuse these bit positions
  assign {funct7, rs2, rs1, funct3, rd, opcode} = fd.insn;

  assign imm_i = {{(`RV_XLEN-12){fd.insn[31]}}, fd.insn[31:20]};
  assign imm_b = {{(`RV_XLEN-13){fd.insn[31]}}, fd.insn[31], fd.insn[7],
                  fd.insn[30:25], fd.insn[11:8], 1'b0};
  assign imm_u = {fd.insn[31:12], 12'b0};

  always_comb begin
    op  = OP_NONE;
    imm = imm_i;
    case (opcode)
      OPC_LUI: begin
        op  = OP_LUI;
        imm = imm_u;
      end
      OPC_BRANCH: begin
        imm = imm_b;
        case (funct3)
          3'b000: op = OP_BEQ;
          3'b001: op = OP_BNE;
          3'b100: op = OP_BLT;
          3'b101: op = OP_BGE;
          3'b110: op = OP_BLTU;
          3'b111: op = OP_BGEU;
          default: op = OP_NONE;
        endcase
      end
      OPC_REG_IMM: begin
        case (funct3)
          3'b000: op = OP_ADDI;
          3'b010: op = OP_SLTI;
          3'b011: op = OP_SLTIU;
          3'b100: op = OP_XORI;
          3'b110: op = OP_ORI;
          3'b111: op = OP_ANDI;
          3'b001: op = (funct7 == F7_BASE) ? OP_SLLI : OP_NONE;
          3'b101: begin
            if (funct7 == F7_BASE) begin
              op = OP_SRLI;
            end else if (funct7 == F7_ALT) begin
              op = OP_SRAI;
            end
          end
          default: op = OP_NONE;
        endcase
      end
      OPC_REG_REG: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            3'b000: op = OP_ADD;
            3'b001: op = OP_SLL;
            3'b010: op = OP_SLT;
            3'b011: op = OP_SLTU;
            3'b100: op = OP_XOR;
            3'b101: op = OP_SRL;
            3'b110: op = OP_OR;
            default: op = OP_AND;
          endcase
        end else if (funct7 == F7_ALT) begin
          if (funct3 == 3'b000) begin
            op = OP_SUB;
          end else if (funct3 == 3'b101) begin
            op = OP_SRA;
          end
        end
      end
      // ecall is the all-zero system encoding, ebreak and csr ops fall through
      OPC_SYSTEM: op = (fd.insn[31:7] == '0) ? OP_ECALL : OP_NONE;
      default: op = OP_NONE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dx <= '{pc: '0, insn: '0, status: CYCLE_RESET, rs1: '0, rs2: '0, rd: '0,
              op: OP_NONE, imm: '0};
    end else if (redirect) begin
      // younger instruction behind a taken branch
      dx <= '{pc: '0, insn: '0, status: CYCLE_TAKEN_BRANCH, rs1: '0, rs2: '0, rd: '0,
              op: OP_NONE, imm: '0};
    end else begin
      dx <= '{pc: fd.pc, insn: fd.insn, status: fd.status, rs1: rs1, rs2: rs2, rd: rd,
              op: op, imm: imm};
    end
  end

endmodule

`default_nettype wire

// File: rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path width of RV32
`define RV_XLEN 32

// five bits name one of the 32 architectural registers
`define RV_REG_IDX_W 5
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// byte distance between sequential instructions
`define RV_PC_STEP 32'd4

`endif

// File: rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  dx_t      dx,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  bypass_t  w_byp,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     redirect,
  output word_t    redirect_pc,
  output xm_t      xm
);

  bypass_t m_byp;
  word_t   op_a;
  word_t   op_b;
  word_t   src_b;
  word_t   result;
  logic    x_we;
  logic    x_halt;
  logic    eq;
  logic    lt;
  logic    ltu;
  logic    taken;

  // memory stage source wins, it holds the younger result
  function automatic word_t bypass_sel(reg_idx_t src, word_t rf_data,
                                       bypass_t m, bypass_t w);
    if (m.we && m.rd != '0 && m.rd == src) begin
      return m.rd_data;
    end else if (w.we && w.rd != '0 && w.rd == src) begin
      return w.rd_data;
    end
    return rf_data;
  endfunction

  assign rs1 = dx.rs1;
  assign rs2 = dx.rs2;

  assign m_byp = '{rd: xm.rd, rd_data: xm.rd_data, we: xm.we};

  assign op_a = bypass_sel(dx.rs1, rs1_data, m_byp, w_byp);
  assign op_b = bypass_sel(dx.rs2, rs2_data, m_byp, w_byp);

  // the immediate ALU ops occupy one contiguous block of op codes
  assign src_b = (dx.op >= OP_ADDI && dx.op <= OP_SRAI) ? dx.imm : op_b;

  always_comb begin
    result = '0;
    x_we   = 1'b1;
    x_halt = 1'b0;
    case (dx.op)
      OP_LUI:           result = dx.imm;
      OP_ADDI, OP_ADD:  result = op_a + src_b;
      OP_SUB:           result = op_a - op_b;
      OP_SLTI, OP_SLT:  result = word_t'($signed(op_a) < $signed(src_b));
      OP_SLTIU, OP_SLTU: result = word_t'(op_a < src_b);
      OP_XORI, OP_XOR:  result = op_a ^ src_b;
      OP_ORI, OP_OR:    result = op_a | src_b;
      OP_ANDI, OP_AND:  result = op_a & src_b;
      OP_SLLI, OP_SLL:  result = op_a << src_b[4:0];
      OP_SRLI, OP_SRL:  result = op_a >> src_b[4:0];
      OP_SRAI, OP_SRA:  result = $signed(op_a) >>> src_b[4:0];
      OP_ECALL: begin
        x_we   = 1'b0;
        x_halt = 1'b1;
      end
      // branches, bubbles and unknown encodings write nothing
      default: x_we = 1'b0;
    endcase
  end

  assign eq  = (op_a == op_b);
  assign lt  = ($signed(op_a) < $signed(op_b));
  assign ltu = (op_a < op_b);

  always_comb begin
    case (dx.op)
      OP_BEQ:  taken = eq;
      OP_BNE:  taken = !eq;
      OP_BLT:  taken = lt;
      OP_BGE:  taken = !lt;
      OP_BLTU: taken = ltu;
      OP_BGEU: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  assign redirect    = taken;
  assign redirect_pc = dx.pc + dx.imm;

  // the branch itself still retires, only the younger pair is squashed
  always_ff @(posedge clk) begin
    if (rst) begin
      xm <= '{pc: '0, insn: '0, status: CYCLE_RESET, rd: '0, rd_data: '0,
              we: 1'b0, halt: 1'b0};
    end else begin
      xm <= '{pc: dx.pc, insn: dx.insn, status: dx.status, rd: dx.rd,
              rd_data: result, we: x_we, halt: x_halt};
    end
  end

  // decode builds the offset, fetch relies on an aligned target
  assert property (@(posedge clk) disable iff (rst)
    redirect |-> redirect_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_fetch import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  redirect,
  input  word_t redirect_pc,
  output word_t pc_to_imem,
  input  insn_t insn_from_imem,
  output fd_t   fd
);

  word_t pc;

  // memory answers in the same cycle, so the pc goes out straight from the register
  assign pc_to_imem = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else begin
      pc <= pc + `RV_PC_STEP;
    end
  end

  // the instruction being fetched is the second one squashed by a taken branch
  always_ff @(posedge clk) begin
    if (rst) begin
      fd <= '{pc: '0, insn: '0, status: CYCLE_RESET};
    end else if (redirect) begin
      fd <= '{pc: '0, insn: '0, status: CYCLE_TAKEN_BRANCH};
    end else begin
      fd <= '{pc: pc, insn: insn_from_imem, status: CYCLE_NO_STALL};
    end
  end

  // both reset and branch targets must keep the fetch address word aligned
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [5:0] op_t;

  // operation codes, numbered like the full RV32IM decoder
  localparam op_t OP_NONE = 6'd0;
  localparam op_t OP_LUI = 6'd1;
  localparam op_t OP_BEQ = 6'd5;
  localparam op_t OP_BNE = 6'd6;
  localparam op_t OP_BLT = 6'd7;
  localparam op_t OP_BGE = 6'd8;
  localparam op_t OP_BLTU = 6'd9;
  localparam op_t OP_BGEU = 6'd10;
  localparam op_t OP_ADDI = 6'd19;
  localparam op_t OP_SLTI = 6'd20;
  localparam op_t OP_SLTIU = 6'd21;
  localparam op_t OP_XORI = 6'd22;
  localparam op_t OP_ORI = 6'd23;
  localparam op_t OP_ANDI = 6'd24;
  localparam op_t OP_SLLI = 6'd25;
  localparam op_t OP_SRLI = 6'd26;
  localparam op_t OP_SRAI = 6'd27;
  localparam op_t OP_ADD = 6'd28;
  localparam op_t OP_SUB = 6'd29;
  localparam op_t OP_SLL = 6'd30;
  localparam op_t OP_SLT = 6'd31;
  localparam op_t OP_SLTU = 6'd32;
  localparam op_t OP_XOR = 6'd33;
  localparam op_t OP_SRL = 6'd34;
  localparam op_t OP_SRA = 6'd35;
  localparam op_t OP_OR = 6'd36;
  localparam op_t OP_AND = 6'd37;
  localparam op_t OP_ECALL = 6'd46;

  // what occupies writeback in a given cycle
  typedef enum logic [2:0] {
    CYCLE_INVALID      = 3'd0,
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd4
  } cycle_status_e;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
  } fd_t;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_idx_t      rd;
    op_t           op;
    word_t         imm;
  } dx_t;

  // also used for the memory-to-writeback register
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    reg_idx_t      rd;
    word_t         rd_data;
    logic          we;
    logic          halt;
  } xm_t;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    reg_idx_t      rd;
    word_t         rd_data;
    logic          we;
  } trace_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    rd_data;
    logic     we;
  } bypass_t;

endpackage

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  bypass_t  wr
);

  word_t [`RV_NUM_REGS-1:0] regs;

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '0;
    end else if (wr.we && wr.rd != '0) begin
      regs[wr.rd] <= wr.rd_data;
    end
  end

  // writeback may present rd = x0 with we set, the array must not move
  assert property (@(posedge clk) disable iff (rst)
    (wr.we && wr.rd == '0) |=> $stable(regs));

endmodule

`default_nettype wire

// File: rv_retire.sv
`timescale 1ns/1ps
`default_nettype none

module rv_retire import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  xm_t     xm,
  output bypass_t w_byp,
  output logic    halt,
  output trace_t  trace
);

  xm_t mw;

  // no data memory, this stage only carries the result one more cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      mw <= '{pc: '0, insn: '0, status: CYCLE_RESET, rd: '0, rd_data: '0,
              we: 1'b0, halt: 1'b0};
    end else begin
      mw <= xm;
    end
  end

  // register file write port and the writeback bypass share one source
  assign w_byp = '{rd: mw.rd, rd_data: mw.rd_data, we: mw.we};

  assign halt = mw.halt;

  assign trace = '{
    pc:      mw.pc,
    insn:    mw.insn,
    status:  mw.status,
    rd:      mw.rd,
    rd_data: mw.rd_data,
    we:      mw.we
  };

endmodule

`default_nettype wire

// File: tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// one retired instruction as the reference model sees it
typedef struct packed {
  trace_t tr;
  logic   taken;
  logic   halt;
} retire_t;

localparam logic [6:0] ENC_LUI = 7'b0110111;
localparam logic [6:0] ENC_BRANCH = 7'b1100011;
localparam logic [6:0] ENC_REG_IMM = 7'b0010011;
localparam logic [6:0] ENC_REG_REG = 7'b0110011;
localparam insn_t ENC_ECALL = 32'h0000_0073;

word_t   model_regs [`RV_NUM_REGS];
retire_t exp_q [$];

// addi x0, x0, index keeps every word distinct and harmless
function automatic void fill_imem();
  for (int i = 0; i < IMEM_WORDS; i++) begin
    imem[i] = {12'(i), 5'd0, 3'd0, 5'd0, ENC_REG_IMM};
  end
endfunction

// half of the sources read the previous result, so both bypass paths see traffic
function automatic reg_idx_t pick_reg(input reg_idx_t prev);
  if ($urandom_range(1) == 0) begin
    return prev;
  end
  return reg_idx_t'($urandom_range(5));
endfunction

// kind 0 alu, 1 branches, 2 lui and shifts, 3 a lone ecall
function automatic int gen_program(input int kind);
  int         n;
  int         pick;
  int         cls;
  int         tgt;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   prev;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [4:0] shamt;
  logic [12:0] off;
  prev = '0;
  n = (kind == 3) ? 1 : 20 + $urandom_range(20);
  for (int i = 0; i < n - 1; i++) begin
    rd = reg_idx_t'($urandom_range(5));
    rs1 = pick_reg(prev);
    rs2 = pick_reg(prev);
    pick = $urandom_range(99);
    f3 = 3'($urandom_range(7));
    f7 = ($urandom_range(1) == 1) ? 7'b0100000 : 7'b0000000;
    case ($urandom_range(2))
      0: shamt = 5'd0;
      1: shamt = 5'd31;
      default: shamt = 5'($urandom_range(31));
    endcase
    if (kind == 1 && pick < 30) begin
      cls = 3;
    end else if (kind == 2) begin
      cls = (pick < 30) ? 0 : (pick < 70) ? 1 : 2;
      f3 = ($urandom_range(1) == 1) ? 3'd5 : 3'd1;
    end else begin
      cls = (pick < 15) ? 0 : (pick < 55) ? 1 : 2;
    end
    case (cls)
      0: imem[i] = {20'($urandom), rd, ENC_LUI};
      1: begin
        if (f3 == 3'd1) begin
          imem[i] = {7'b0000000, shamt, rs1, f3, rd, ENC_REG_IMM};
        end else if (f3 == 3'd5) begin
          imem[i] = {f7, shamt, rs1, f3, rd, ENC_REG_IMM};
        end else begin
          imem[i] = {12'($urandom), rs1, f3, rd, ENC_REG_IMM};
        end
      end
      2: begin
        // only add and the right shift have an alternate form
        if (f3 != 3'd0 && f3 != 3'd5) begin
          f7 = 7'b0000000;
        end
        imem[i] = {f7, rs2, rs1, f3, rd, ENC_REG_REG};
      end
      default: begin
        // forward only, at most to the closing ecall
        f3 = 3'($urandom_range(5));
        if (f3 >= 3'd2) begin
          f3 = f3 + 3'd2;
        end
        tgt = i + 1 + $urandom_range((n - 2 - i < 5) ? n - 2 - i : 5);
        off = 13'((tgt - i) * 4);
        imem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], ENC_BRANCH};
      end
    endcase
    if (cls != 3) begin
      prev = rd;
    end
  end
  imem[n-1] = ENC_ECALL;
  return n;
endfunction

function automatic word_t alu_result(input logic [2:0] f3, input logic sub,
                                     input logic arith, input word_t a, input word_t b);
  case (f3)
    3'd0: return sub ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return word_t'($signed(a) < $signed(b));
    3'd3: return word_t'(a < b);
    3'd4: return a ^ b;
    3'd5: begin
      if (arith) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

task automatic exec_one(input word_t pc, output word_t next_pc, output retire_t r);
  insn_t insn;
  word_t a;
  word_t b;
  word_t imm;
  logic  is_reg;
  insn = imem[pc[IMEM_AW+1:2]];
  a = model_regs[insn[19:15]];
  b = model_regs[insn[24:20]];
  imm = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  is_reg = (insn[6:0] == ENC_REG_REG);
  r = '0;
  r.tr = '{pc: pc, insn: insn, status: CYCLE_NO_STALL, rd: insn[11:7], rd_data: '0, we: 1'b0};
  next_pc = pc + `RV_PC_STEP;
  case (insn[6:0])
    ENC_LUI: begin
      r.tr.we = 1'b1;
      r.tr.rd_data = {insn[31:12], 12'h000};
    end
    ENC_REG_IMM, ENC_REG_REG: begin
      r.tr.we = 1'b1;
      r.tr.rd_data = alu_result(insn[14:12], is_reg && insn[30], insn[30], a,
                                is_reg ? b : imm);
    end
    ENC_BRANCH: begin
      case (insn[14:12])
        3'd0: r.taken = (a == b);
        3'd1: r.taken = (a != b);
        3'd4: r.taken = ($signed(a) < $signed(b));
        3'd5: r.taken = ($signed(a) >= $signed(b));
        3'd6: r.taken = (a < b);
        default: r.taken = (a >= b);
      endcase
      if (r.taken) begin
        next_pc = pc + {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25],
                        insn[11:8], 1'b0};
      end
    end
    default: r.halt = (insn == ENC_ECALL);
  endcase
  // x0 stays zero, the write itself still shows on the trace
  if (r.tr.we && r.tr.rd != '0) begin
    model_regs[r.tr.rd] = r.tr.rd_data;
  end
endtask

task automatic build_expected();
  word_t   pc;
  word_t   next_pc;
  retire_t r;
  int      steps;
  foreach (model_regs[k]) begin
    model_regs[k] = '0;
  end
  exp_q.delete();
  pc = `RV_RESET_PC;
  steps = 0;
  r = '0;
  while (!r.halt && steps < IMEM_WORDS) begin
    exec_one(pc, next_pc, r);
    exp_q.push_back(r);
    pc = next_pc;
    steps++;
  end
endtask

`endif

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam int IMEM_AW = 8;
  localparam int IMEM_WORDS = 1 << IMEM_AW;
  localparam int RUN_TIMEOUT = 600;
  localparam int RESET_CYCLES = 5;
  localparam int unsigned SEED = 32'h358c_abba;

  logic   clk;
  logic   rst;
  word_t  pc_to_imem;
  insn_t  insn_from_imem;
  logic   halt;
  trace_t trace;

  insn_t imem [IMEM_WORDS];
  int    errors;
  int    tests_run;
  int    tests_failed;

  `include "tb_rv_model.svh"

  rv_core dut (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .halt           (halt),
    .trace          (trace)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // instruction for the new pc, ready well before the next edge
  always @(posedge clk) begin
    #1;
    insn_from_imem = imem[pc_to_imem[IMEM_AW+1:2]];
  end

  task automatic compare_field(input string name, input word_t got, input word_t want);
    assert (got === want) else begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // four pipeline registers drain the reset bubbles
  task automatic check_reset_window();
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      compare_field("trace.status", word_t'(trace.status), word_t'(CYCLE_RESET));
      compare_field("trace.we", word_t'(trace.we), '0);
      compare_field("halt", word_t'(halt), '0);
    end
  endtask

  task automatic run_program(input int kind);
    retire_t want;
    int      n;
    int      cycles;
    int      bubbles;
    logic    done;
    fill_imem();
    n = gen_program(kind);
    build_expected();
    apply_reset();
    check_reset_window();
    cycles = 0;
    bubbles = 0;
    done = 1'b0;
    while (!done && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (trace.status == CYCLE_TAKEN_BRANCH) begin
        assert (bubbles > 0) else begin
          errors++;
          $display("taken-branch bubble at %0t ns with no taken branch before it", $time);
        end
        compare_field("trace.we", word_t'(trace.we), '0);
        compare_field("halt", word_t'(halt), '0);
        if (bubbles > 0) begin
          bubbles--;
        end
      end else begin
        assert (trace.status == CYCLE_NO_STALL) else begin
          errors++;
          $display("error at %0t ns: trace.status is %0d, expected %0d or %0d",
                   $time, trace.status, CYCLE_NO_STALL, CYCLE_TAKEN_BRANCH);
        end
        if (trace.status == CYCLE_NO_STALL) begin
          assert (bubbles == 0) else begin
            errors++;
            $display("instruction retired at %0t ns before both taken-branch bubbles", $time);
          end
          bubbles = 0;
          want = exp_q.pop_front();
          compare_field("trace.pc", trace.pc, want.tr.pc);
          compare_field("trace.insn", trace.insn, want.tr.insn);
          compare_field("trace.we", word_t'(trace.we), word_t'(want.tr.we));
          if (want.tr.we) begin
            compare_field("trace.rd", word_t'(trace.rd), word_t'(want.tr.rd));
            compare_field("trace.rd_data", trace.rd_data, want.tr.rd_data);
          end
          compare_field("halt", word_t'(halt), word_t'(want.halt));
          if (want.taken) begin
            bubbles = 2;
          end
          done = want.halt;
        end
      end
    end
    assert (done) else begin
      errors++;
      $display("no ECALL retired within %0d cycles of a %0d-instruction program",
               RUN_TIMEOUT, n);
    end
  endtask

  task automatic finish_test(input string name, input int programs, input int start);
    tests_run++;
    if (errors > start) begin
      tests_failed++;
    end
    $display("test %-10s %0d program(s), %0d failed check(s)", name, programs, errors - start);
  endtask

  task automatic run_test(input string name, input int kind, input int count);
    int start;
    start = errors;
    for (int p = 0; p < count; p++) begin
      run_program(kind);
    end
    finish_test(name, count, start);
  endtask

  initial begin
    int start;
    rst = 1'b1;
    insn_from_imem = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(SEED));
    fill_imem();

    start = errors;
    apply_reset();
    check_reset_window();
    // the word at the reset pc reaches writeback right after the window
    @(negedge clk);
    compare_field("trace.status", word_t'(trace.status), word_t'(CYCLE_NO_STALL));
    compare_field("trace.pc", trace.pc, `RV_RESET_PC);
    compare_field("trace.insn", trace.insn, imem[0]);
    finish_test("reset", 1, start);

    run_test("alu", 0, 6);
    run_test("branch", 1, 8);
    run_test("lui_shift", 2, 6);

    // a lone ecall first, then full programs that end in one
    start = errors;
    run_program(3);
    run_program(1);
    run_program(0);
    run_program(1);
    finish_test("halt", 4, start);

    $display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_retire.sv
rv_core.sv
tb_rv_core.sv
